// File: hdl/vendPkg.sv
`default_nettype none

package vendPkg;

    typedef logic [9:0] centsT;     // money in cents, covers the 500 cap plus one coin
    typedef logic [8:0] itemVecT;   // one bit per item slot
    typedef logic [5:0] coinVecT;   // one bit per coin denomination

    localparam int itemCount = 9;   // slots A1..C3, index 0..8
    localparam int coinCount = 6;

    // coin values, index 0 is the nickel
    localparam centsT coinValue [0:coinCount-1] = '{
        10'd5,                      // nickel
        10'd10,                     // dime
        10'd25,                     // quarter
        10'd50,                     // half dollar
        10'd100,                    // dollar
        10'd500                     // five dollar bill
    };

    localparam centsT maxCredit = 10'd500;  // coins that would pass this are refused

    // price per slot, zero marks an empty slot
    localparam centsT itemPrice [0:itemCount-1] = '{
        10'd100,                    // A1
        10'd0,                      // A2, out of stock
        10'd125,                    // A3
        10'd175,                    // B1
        10'd225,                    // B2
        10'd250,                    // B3
        10'd100,                    // C1
        10'd325,                    // C2
        10'd375                     // C3
    };

endpackage

`default_nettype wire

// File: hdl/segPkg.sv
`default_nettype none

package segPkg;

    typedef logic [7:0] segT;       // g..a in bits 7..1, point in bit 0, active low
    typedef logic [3:0] anodeT;     // digit enables, active low

    localparam int digitCount = 4;

    // glyphs for 0..9, point off
    localparam segT segDigit [0:9] = '{
        8'b10000001,                // 0
        8'b11110011,                // 1
        8'b01001001,                // 2
        8'b01100001,                // 3
        8'b00110011,                // 4
        8'b00100101,                // 5
        8'b00000101,                // 6
        8'b11110001,                // 7
        8'b00000001,                // 8
        8'b00100001                 // 9
    };

    localparam segT segMinus     = 8'b01111111;  // only the middle bar lit
    localparam segT segPointMask = 8'b11111110;  // and-ing pulls the point low, lighting it

    // anode pattern per digit position, digit 0 is the rightmost
    localparam anodeT anodeSel [0:digitCount-1] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

endpackage

`default_nettype wire

// File: hdl/segIf.sv
`timescale 1ns/1ps
`default_nettype none

interface segIf import segPkg::*; ();

    segT digit0;    // cents ones
    segT digit1;    // cents tens
    segT digit2;    // dollars, may carry the point
    segT digit3;    // sign position

    modport encoder (
        output digit0, digit1, digit2, digit3
    );

    modport scanner (
        input digit0, digit1, digit2, digit3
    );

endinterface

`default_nettype wire

// File: hdl/inputSync.sv
`timescale 1ns/1ps
`default_nettype none

module inputSync import vendPkg::*; (
    input  wire logic                           A1,
    input  wire logic                           A2,
    input  wire itemVecT                        itemBtn,
    input  wire coinVecT                        coinBtn,
    input  wire logic                           cancelBtn,
    output logic                                itemEvt,
    output logic [$clog2(itemCount)-1:0]        itemIdx,
    output logic                                coinEvt,
    output logic [$clog2(coinCount)-1:0]        coinIdx,
    output logic                                cancelEvt
);

    localparam int btnBits = itemCount + coinCount + 1;  // cancel sits in the top bit

    logic [btnBits-1:0] meta;       // first sync stage
    logic [btnBits-1:0] sync;       // second sync stage
    logic [btnBits-1:0] prev;       // last synced sample for edge detect
    logic [btnBits-1:0] rise;

    logic                               cancelRise;
    logic                               anyCoin;
    logic                               anyItem;
    logic [$clog2(itemCount)-1:0]       itemPick;
    logic [$clog2(coinCount)-1:0]       coinPick;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            meta <= '0;
            sync <= '0;
            prev <= '0;
        end else begin
            meta <= {cancelBtn, coinBtn, itemBtn};
            sync <= meta;
            prev <= sync;
        end
    end

    assign rise       = sync & ~prev;                           // one cycle per press
    assign cancelRise = rise[btnBits-1];
    assign anyCoin    = |rise[itemCount +: coinCount];
    assign anyItem    = |rise[0 +: itemCount];

    // scan downwards so the lowest set bit is the last one written
    always_comb begin
        itemPick = '0;
        coinPick = '0;
        for (int i = itemCount - 1; i >= 0; i--) begin
            if (rise[i]) itemPick = i[$clog2(itemCount)-1:0];
        end
        for (int i = coinCount - 1; i >= 0; i--) begin
            if (rise[itemCount + i]) coinPick = i[$clog2(coinCount)-1:0];
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            cancelEvt <= 1'b0;
            coinEvt   <= 1'b0;
            itemEvt   <= 1'b0;
            coinIdx   <= '0;
            itemIdx   <= '0;
        end else begin
            cancelEvt <= cancelRise;                            // cancel beats everything
            coinEvt   <= anyCoin & ~cancelRise;
            itemEvt   <= anyItem & ~anyCoin & ~cancelRise;      // losers are dropped
            coinIdx   <= coinPick;
            itemIdx   <= itemPick;
        end
    end

endmodule

`default_nettype wire

// File: hdl/vendControl.sv
`timescale 1ns/1ps
`default_nettype none

module vendControl import vendPkg::*; (
    input  wire logic                           A1,
    input  wire logic                           A2,
    input  wire logic                           itemEvt,
    input  wire logic [$clog2(itemCount)-1:0]   itemIdx,
    input  wire logic                           coinEvt,
    input  wire logic [$clog2(coinCount)-1:0]   coinIdx,
    input  wire logic                           cancelEvt,
    output centsT                               dispAmount,
    output logic                                dispNegative,
    output logic                                dispPoint,
    output itemVecT                             gLed,
    output itemVecT                             rLed,
    output itemVecT                             dLed
);

    centsT credit;      // money inserted so far
    centsT coinSum;     // credit if the current coin were taken
    centsT price;       // price of the pressed slot

    assign coinSum = credit + coinValue[coinIdx];   // at most 1000, no wrap
    assign price   = itemPrice[itemIdx];

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit       <= '0;
            dLed         <= '0;
            dispAmount   <= '0;
            dispNegative <= 1'b0;
            dispPoint    <= 1'b0;
        end else if (cancelEvt) begin
            credit       <= '0;                     // drop credit and vend lamps
            dLed         <= '0;
            dispAmount   <= '0;
            dispNegative <= 1'b0;
            dispPoint    <= 1'b0;                   // plain 0000
        end else if (coinEvt) begin
            if (coinSum <= maxCredit) begin
                credit       <= coinSum;
                dLed         <= '0;                 // new purchase starts
                dispAmount   <= coinSum;
                dispNegative <= 1'b0;
                dispPoint    <= 1'b1;
            end
            // over the cap, coin is refused and state holds
        end else if (itemEvt) begin
            dispPoint    <= 1'b1;                   // every item response is money
            dispNegative <= 1'b0;
            if (credit == '0) begin
                dispAmount <= price;                // price check only
            end else if (price == '0) begin
                dispAmount <= '0;                   // empty slot
            end else if (credit >= price) begin
                dispAmount <= credit - price;       // change due
                dLed       <= itemVecT'(1) << itemIdx;
                credit     <= '0;
            end else begin
                dispAmount   <= price - credit;     // still owed
                dispNegative <= 1'b1;
            end
        end
    end

    // lamps follow credit and the fixed price table
    always_comb begin
        for (int i = 0; i < itemCount; i++) begin
            gLed[i] = (credit >= itemPrice[i]) && (itemPrice[i] != '0);
            rLed[i] = (itemPrice[i] == '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/amountEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module amountEncoder import vendPkg::*, segPkg::*; (
    input  wire centsT  dispAmount,
    input  wire logic   dispNegative,
    input  wire logic   dispPoint,
    segIf.encoder       segBus
);

    localparam int bcdDigits = 3;               // digit 3 is sign only

    logic [4*bcdDigits-1:0] bcd;                // ones, tens, hundreds of cents
    segT                    hundredsSeg;

    // shift-and-add-three, one input bit per pass, msb first
    always_comb begin
        bcd = '0;
        for (int i = $bits(centsT) - 1; i >= 0; i--) begin
            for (int d = 0; d < bcdDigits; d++) begin
                if (bcd[4*d +: 4] >= 4'd5) begin
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;   // pre-correct before doubling
                end
            end
            bcd = {bcd[4*bcdDigits-2:0], dispAmount[i]};
        end
    end

    assign hundredsSeg = segDigit[bcd[11:8]];

    assign segBus.digit0 = segDigit[bcd[3:0]];
    assign segBus.digit1 = segDigit[bcd[7:4]];
    assign segBus.digit2 = dispPoint ? (hundredsSeg & segPointMask) : hundredsSeg;  // dollar point
    assign segBus.digit3 = dispNegative ? segMinus : segDigit[0];

endmodule

`default_nettype wire

// File: hdl/digitScan.sv
`timescale 1ns/1ps
`default_nettype none

module digitScan import segPkg::*; #(
    parameter int scanDivBits = 17          // digit dwell is 2**scanDivBits clocks
) (
    input  wire logic   A1,
    input  wire logic   A2,
    segIf.scanner       segBus,
    output anodeT       anode,
    output segT         segment
);

    localparam int selBits = $clog2(digitCount);

    logic [scanDivBits+selBits-1:0] divCnt;  // free running, top bits pick the digit
    logic [selBits-1:0]             digitSel;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) divCnt <= '0;
        else    divCnt <= divCnt + 1'b1;
    end

    assign digitSel = divCnt[scanDivBits +: selBits];
    assign anode    = anodeSel[digitSel];   // same select as segment, so both move together

    always_comb begin
        case (digitSel)
            2'd0:    segment = segBus.digit0;
            2'd1:    segment = segBus.digit1;
            2'd2:    segment = segBus.digit2;
            default: segment = segBus.digit3;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/vendTop.sv
`timescale 1ns/1ps
`default_nettype none

module vendTop import vendPkg::*, segPkg::*; #(
    parameter int scanDivBits = 17          // shrink in simulation
) (
    input  wire logic       A1,
    input  wire logic       A2,
    input  wire itemVecT    itemBtn,
    input  wire coinVecT    coinBtn,
    input  wire logic       cancelBtn,
    output itemVecT         gLed,
    output itemVecT         rLed,
    output itemVecT         dLed,
    output anodeT           anode,
    output segT             segment
);

    logic                           itemEvt;
    logic [$clog2(itemCount)-1:0]   itemIdx;
    logic                           coinEvt;
    logic [$clog2(coinCount)-1:0]   coinIdx;
    logic                           cancelEvt;

    centsT  dispAmount;
    logic   dispNegative;
    logic   dispPoint;

    segIf segBus ();                        // encoded digits to the scanner

    inputSync u_inputSync (
        .A1         (A1),
        .A2         (A2),
        .itemBtn    (itemBtn),
        .coinBtn    (coinBtn),
        .cancelBtn  (cancelBtn),
        .itemEvt    (itemEvt),
        .itemIdx    (itemIdx),
        .coinEvt    (coinEvt),
        .coinIdx    (coinIdx),
        .cancelEvt  (cancelEvt)
    );

    vendControl u_vendControl (
        .A1           (A1),
        .A2           (A2),
        .itemEvt      (itemEvt),
        .itemIdx      (itemIdx),
        .coinEvt      (coinEvt),
        .coinIdx      (coinIdx),
        .cancelEvt    (cancelEvt),
        .dispAmount   (dispAmount),
        .dispNegative (dispNegative),
        .dispPoint    (dispPoint),
        .gLed         (gLed),
        .rLed         (rLed),
        .dLed         (dLed)
    );

    amountEncoder u_amountEncoder (
        .dispAmount   (dispAmount),
        .dispNegative (dispNegative),
        .dispPoint    (dispPoint),
        .segBus       (segBus.encoder)
    );

    digitScan #(
        .scanDivBits (scanDivBits)
    ) u_digitScan (
        .A1      (A1),
        .A2      (A2),
        .segBus  (segBus.scanner),
        .anode   (anode),
        .segment (segment)
    );

endmodule

`default_nettype wire

// File: verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter time halfPeriod = 2           // 4 ns period
) (
    output logic A1
);

    initial begin
        A1 = 1'b0;
        forever #halfPeriod A1 = ~A1;
    end

endmodule

`default_nettype wire

// File: verification/vendTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module vendTopTb import vendPkg::*, segPkg::*; ();

    localparam int scanTimeout = 64;        // a full scan takes 16 cycles at scanDivBits 2
    localparam int randomSteps = 80;
    localparam itemVecT outOfStock = 9'b000000010;  // only slot 1 is empty

    logic       A1;
    logic       A2;
    itemVecT    itemBtn;
    coinVecT    coinBtn;
    logic       cancelBtn;
    itemVecT    gLed;
    itemVecT    rLed;
    itemVecT    dLed;
    anodeT      anode;
    segT        segment;

    // reference model state
    int         credit;
    itemVecT    dLedModel;
    int         dispAmt;
    bit         dispNeg;
    bit         dispPt;

    int         mismatchCount;
    int         timeoutCount;

    tbClock u_tbClock (.A1(A1));

    vendTop #(.scanDivBits(2)) u_vendTop (
        .A1        (A1),
        .A2        (A2),
        .itemBtn   (itemBtn),
        .coinBtn   (coinBtn),
        .cancelBtn (cancelBtn),
        .gLed      (gLed),
        .rLed      (rLed),
        .dLed      (dLed),
        .anode     (anode),
        .segment   (segment)
    );

    task automatic modelCancel();
        credit    = 0;
        dLedModel = '0;
        dispAmt   = 0;
        dispNeg   = 1'b0;
        dispPt    = 1'b0;                   // blank 0000, no point
    endtask

    task automatic modelCoin(input int idx);
        int sum;
        sum = credit + int'(coinValue[idx]);
        if (sum <= 500) begin               // refused coins leave everything alone
            credit    = sum;
            dLedModel = '0;
            dispAmt   = sum;
            dispNeg   = 1'b0;
            dispPt    = 1'b1;
        end
    endtask

    task automatic modelItem(input int idx);
        int price;
        price   = int'(itemPrice[idx]);
        dispPt  = 1'b1;
        dispNeg = 1'b0;
        if (credit == 0) begin
            dispAmt = price;                // price lookup only
        end else if (price == 0) begin
            dispAmt = 0;
        end else if (credit >= price) begin
            dispAmt   = credit - price;     // change
            dLedModel = '0;
            dLedModel[idx] = 1'b1;
            credit    = 0;
        end else begin
            dispAmt = price - credit;       // shortfall
            dispNeg = 1'b1;
        end
    endtask

    // cancel, then coins, then items; lowest index inside a group
    task automatic modelPress(input itemVecT itemV, input coinVecT coinV, input bit cancel);
        int pick;
        pick = -1;
        if (cancel) begin
            modelCancel();
        end else if (coinV != '0) begin
            for (int i = coinCount - 1; i >= 0; i--) begin
                if (coinV[i]) pick = i;
            end
            modelCoin(pick);
        end else if (itemV != '0) begin
            for (int i = itemCount - 1; i >= 0; i--) begin
                if (itemV[i]) pick = i;
            end
            modelItem(pick);
        end
    endtask

    function automatic segT expectedSeg(input int pos);
        int  digitVal;
        segT pattern;
        if (pos == 3) begin
            return dispNeg ? segMinus : segDigit[0];
        end
        digitVal = (dispAmt / (10 ** pos)) % 10;
        pattern  = segDigit[digitVal];
        if (pos == 2 && dispPt) pattern = pattern & segPointMask;   // dollar point
        return pattern;
    endfunction

    task automatic checkLamps(input string tag);
        itemVecT gWant;
        itemVecT rWant;
        rWant = outOfStock;
        for (int i = 0; i < itemCount; i++) begin
            gWant[i] = (credit >= int'(itemPrice[i])) && (itemPrice[i] != '0);
        end
        @(negedge A1);                      // outputs settled mid cycle
        if (gLed !== gWant) begin
            $display("mismatch at %0t: %s gLed %b expected %b", $time, tag, gLed, gWant);
            mismatchCount++;
        end
        if (rLed !== rWant) begin
            $display("mismatch at %0t: %s rLed %b expected %b", $time, tag, rLed, rWant);
            mismatchCount++;
        end
        if (dLed !== dLedModel) begin
            $display("mismatch at %0t: %s dLed %b expected %b", $time, tag, dLed, dLedModel);
            mismatchCount++;
        end
    endtask

    task automatic checkDisplay(input string tag);
        anodeT want;
        int    waited;
        for (int pos = 0; pos < 4; pos++) begin
            want   = ~(anodeT'(1) << pos);  // active low select
            waited = 0;
            @(negedge A1);
            while (anode !== want && waited < scanTimeout) begin
                @(negedge A1);
                waited++;
            end
            if (anode !== want) begin
                $display("%s: anode pattern %b did not appear within %0d cycles",
                         tag, want, scanTimeout);
                timeoutCount++;
            end else if (segment !== expectedSeg(pos)) begin
                $display("mismatch at %0t: %s digit %0d segment %b expected %b",
                         $time, tag, pos, segment, expectedSeg(pos));
                mismatchCount++;
            end
        end
    endtask

    // hold 4 cycles, release, let the sync chain drain
    task automatic pressButtons(input itemVecT itemV, input coinVecT coinV, input bit cancel,
                                input string tag);
        @(posedge A1);
        #1;
        itemBtn   = itemV;
        coinBtn   = coinV;
        cancelBtn = cancel;
        repeat (4) @(posedge A1);
        #1;
        itemBtn   = '0;
        coinBtn   = '0;
        cancelBtn = 1'b0;
        repeat (8) @(posedge A1);
        modelPress(itemV, coinV, cancel);
        checkLamps(tag);
        checkDisplay(tag);
    endtask

    initial begin
        int      action;
        itemVecT itemV;
        coinVecT coinV;
        bit      cancel;
        A2            = 1'b1;
        itemBtn       = '0;
        coinBtn       = '0;
        cancelBtn     = 1'b0;
        mismatchCount = 0;
        timeoutCount  = 0;
        void'($urandom(32'hc75d));
        modelCancel();
        repeat (4) @(posedge A1);
        #1;
        A2 = 1'b0;
        checkLamps("reset");                // red lamp on item 1 only
        if (anode !== 4'b1110) begin        // scan starts on digit 0
            $display("mismatch at %0t: reset anode %b expected 1110", $time, anode);
            mismatchCount++;
        end
        checkDisplay("reset");

        for (int i = 0; i < itemCount; i++) begin
            pressButtons(itemVecT'(1) << i, '0, 1'b0, "price");
        end

        // directed corners: cap refusal and the empty slot with credit
        pressButtons('0, coinVecT'(1) << 5, 1'b0, "coin 500");
        pressButtons('0, coinVecT'(1) << 0, 1'b0, "coin over cap");
        pressButtons('0, '0, 1'b1, "cancel");
        pressButtons('0, coinVecT'(1) << 2, 1'b0, "coin 25");
        pressButtons(itemVecT'(1) << 1, '0, 1'b0, "empty slot");
        pressButtons(itemVecT'(1) << 8, '0, 1'b0, "shortfall");

        for (int step = 0; step < randomSteps; step++) begin
            action = $urandom_range(0, 99);
            itemV  = '0;
            coinV  = '0;
            cancel = 1'b0;
            if (action < 50) begin
                coinV[$urandom_range(0, coinCount - 1)] = 1'b1;
            end else if (action < 78) begin
                itemV[$urandom_range(0, itemCount - 1)] = 1'b1;
            end else if (action < 86) begin
                cancel = 1'b1;
            end else begin
                itemV  = itemVecT'($urandom_range(0, 511));  // several at once
                coinV  = coinVecT'($urandom_range(0, 63));
                cancel = ($urandom_range(0, 3) == 0);
            end
            pressButtons(itemV, coinV, cancel, "random");
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vendTop.f
hdl/vendPkg.sv
hdl/segPkg.sv
hdl/segIf.sv
hdl/inputSync.sv
hdl/vendControl.sv
hdl/amountEncoder.sv
hdl/digitScan.sv
hdl/vendTop.sv
verification/tbClock.sv
verification/vendTopTb.sv
